// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vst_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vst.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard design/*.sv) $(wildcard dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN) dv/vst_tests.txt
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/vst_addrgen.sv ====
`timescale 1ns/1ns

module vst_addrgen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Issuing instruction
  input  logic                 iss_valid_i,
  input  vst_pkg::addr_t       iss_addr_i,
  input  vst_pkg::nbytes_t     iss_bytes_i,
  // AW channel
  output vst_pkg::addr_t       aw_addr_o,
  output vst_pkg::burst_len_t  aw_len_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  // Events towards the control
  output logic                 aw_fire_o,
  output logic                 ag_insn_last_o,
  // Burst handed to the packer
  output logic                 burst_valid_o,
  output vst_pkg::burst_len_t  burst_len_o,
  input  logic                 burst_done_i
);

  vst_pkg::addrgen_state_e state_q, state_d;

  // Next burst address and bytes still to request
  vst_pkg::addr_t      addr_q;
  vst_pkg::nbytes_t    rem_q;
  vst_pkg::nbytes_t    burst_bytes;

  logic                burst_valid_q;
  vst_pkg::burst_len_t burst_len_q;
  logic                load;

  // A burst is at most four full beats
  assign burst_bytes = (rem_q > vst_pkg::nbytes_t'(vst_pkg::BurstBytes)) ?
                       vst_pkg::nbytes_t'(vst_pkg::BurstBytes) : rem_q;

  // Beats minus one, partial last beat rounds up
  assign aw_len_o = vst_pkg::burst_len_t'((burst_bytes - 1'b1) >> $clog2(vst_pkg::BeatBytes));

  assign aw_addr_o      = addr_q;
  assign aw_valid_o     = (state_q == vst_pkg::AG_REQ);
  assign aw_fire_o      = aw_valid_o && aw_ready_i;
  assign ag_insn_last_o = aw_fire_o && (rem_q == burst_bytes);

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait for the packer to drain the previous burst so AW and W stay in order
      vst_pkg::AG_IDLE: begin
        if (!burst_valid_q && (rem_q != '0 || iss_valid_i)) begin
          state_d = vst_pkg::AG_REQ;
        end
      end
      vst_pkg::AG_REQ: begin
        if (aw_ready_i) begin
          state_d = vst_pkg::AG_IDLE;
        end
      end
      default: state_d = vst_pkg::AG_IDLE;
    endcase
  end

  // Nothing left of the old instruction, pick up the next one
  assign load = (state_q == vst_pkg::AG_IDLE) && (state_d == vst_pkg::AG_REQ) && (rem_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= vst_pkg::AG_IDLE;
      rem_q         <= '0;
      burst_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load) begin
        rem_q <= iss_bytes_i;
      end else if (aw_fire_o) begin
        rem_q <= rem_q - burst_bytes;
      end
      // Burst lives from its AW handshake to its last W beat
      if (aw_fire_o) begin
        burst_valid_q <= 1'b1;
      end else if (burst_done_i) begin
        burst_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_q <= iss_addr_i;
    end else if (aw_fire_o) begin
      addr_q <= addr_q + vst_pkg::addr_t'(vst_pkg::BurstBytes);
    end
    if (aw_fire_o) begin
      burst_len_q <= aw_len_o;
    end
  end

  assign burst_valid_o = burst_valid_q;
  assign burst_len_o   = burst_len_q;

endmodule

// ==== design/vst_beat_packer.sv ====
`timescale 1ns/1ns

module vst_beat_packer (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Issuing instruction
  input  logic                                   iss_valid_i,
  input  vst_pkg::nbytes_t                       iss_bytes_i,
  input  vst_pkg::eew_e                          iss_eew_i,
  input  logic                                   iss_vm_i,
  // Current burst from the address generator
  input  logic                                   burst_valid_i,
  input  vst_pkg::burst_len_t                    burst_len_i,
  output logic                                   burst_done_o,
  output logic                                   pk_insn_done_o,
  // Lane operands and mask
  input  vst_pkg::elen_t [vst_pkg::NrLanes-1:0]  opnd_i,
  input  logic                                   opnd_valid_i,
  input  vst_pkg::strb_t [vst_pkg::NrLanes-1:0]  mask_i,
  output logic                                   opnd_ready_o,
  // W channel
  output vst_pkg::elen_t                         w_data_o,
  output vst_pkg::strb_t                         w_strb_o,
  output logic                                   w_last_o,
  output logic                                   w_valid_o,
  input  logic                                   w_ready_i
);

  // Byte pointer into the 16-byte lane word, only 0 or 8 with aligned bases
  logic [3:0]          ptr_q;
  logic [4:0]          ptr_next;
  // Beat index inside the current burst
  vst_pkg::burst_len_t beat_cnt_q;
  // Bytes already written for this instruction
  vst_pkg::nbytes_t    sent_q;
  vst_pkg::nbytes_t    rem;

  logic [3:0] beat_bytes;
  logic [3:0] elem_lsb;
  logic       insn_end;
  logic       word_done;
  logic       fire;

  assign rem = iss_bytes_i - sent_q;

  // Full beat unless the instruction ends inside it
  assign beat_bytes = (rem >= vst_pkg::nbytes_t'(vst_pkg::BeatBytes)) ?
                      4'(vst_pkg::BeatBytes) : rem[3:0];
  assign insn_end   = (rem <= vst_pkg::nbytes_t'(vst_pkg::BeatBytes));

  assign ptr_next  = {1'b0, ptr_q} + 5'(beat_bytes);
  assign word_done = (ptr_next == 5'(vst_pkg::LaneWordBytes)) || insn_end;

  // Low address bits inside one element
  assign elem_lsb = 4'((1 << iss_eew_i) - 1);

  // Beat needs an accepted AW and both lane words
  assign w_valid_o = iss_valid_i && burst_valid_i && opnd_valid_i;
  assign fire      = w_valid_o && w_ready_i;
  assign w_last_o  = (beat_cnt_q == burst_len_i);

  assign burst_done_o   = fire && w_last_o;
  assign pk_insn_done_o = fire && insn_end;
  // Release the lane word once drained or at the instruction tail
  assign opnd_ready_o   = fire && word_done;

  // Sequential copy, lane 0 bytes first
  always_comb begin
    logic [3:0] src;
    logic [3:0] msk;
    w_data_o = '0;
    w_strb_o = '0;
    for (int k = 0; k < vst_pkg::BeatBytes; k++) begin
      src = ptr_q + 4'(k);
      // Mask bit sits on the first byte of each element
      msk = src & ~elem_lsb;
      if (4'(k) < beat_bytes) begin
        w_data_o[8*k +: 8] = opnd_i[src[3]][8*src[2:0] +: 8];
        w_strb_o[k]        = iss_vm_i || mask_i[msk[3]][msk[2:0]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= '0;
      beat_cnt_q <= '0;
      sent_q     <= '0;
    end else if (fire) begin
      if (word_done) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_next[3:0];
      end
      if (w_last_o) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      // Restart the byte count for the next instruction
      if (insn_end) begin
        sent_q <= '0;
      end else begin
        sent_q <= sent_q + vst_pkg::nbytes_t'(beat_bytes);
      end
    end
  end

endmodule

// ==== design/vst_ctrl.sv ====
`timescale 1ns/1ns

module vst_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer request
  input  logic               req_valid_i,
  input  vst_pkg::insn_id_t  req_id_i,
  input  vst_pkg::addr_t     req_addr_i,
  input  vst_pkg::vlen_t     req_vl_i,
  input  vst_pkg::eew_e      req_eew_i,
  input  logic               req_vm_i,
  output logic               req_ready_o,
  // Instruction being issued to the datapath
  output logic               iss_valid_o,
  output vst_pkg::addr_t     iss_addr_o,
  output vst_pkg::nbytes_t   iss_bytes_o,
  output vst_pkg::eew_e      iss_eew_o,
  output logic               iss_vm_o,
  // Datapath events
  input  logic               aw_fire_i,
  input  logic               ag_insn_last_i,
  input  logic               pk_insn_done_i,
  // Write response channel
  input  logic               b_valid_i,
  output logic               b_ready_o,
  // Status
  output logic               store_pending_o,
  output logic               done_valid_o,
  output vst_pkg::insn_id_t  done_id_o
);

  // Queue payload, written at accept
  vst_pkg::insn_id_t id_q    [vst_pkg::QueueDepth];
  vst_pkg::addr_t    addr_q  [vst_pkg::QueueDepth];
  vst_pkg::nbytes_t  bytes_q [vst_pkg::QueueDepth];
  vst_pkg::eew_e     eew_q   [vst_pkg::QueueDepth];
  logic              vm_q    [vst_pkg::QueueDepth];

  // Accept, issue and commit phases
  vst_pkg::qptr_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  vst_pkg::qcnt_t issue_cnt_q, issue_cnt_d;
  vst_pkg::qcnt_t commit_cnt_q, commit_cnt_d;

  // Per entry B bookkeeping
  vst_pkg::burst_cnt_t [vst_pkg::QueueDepth-1:0] out_cnt_q, out_cnt_d;
  logic [vst_pkg::QueueDepth-1:0] issued_q, issued_d;

  logic req_ready_q;
  logic b_ready_q;
  logic done_valid_q;
  vst_pkg::insn_id_t done_id_q;

  logic accept;
  logic b_fire;
  logic retire;

  assign accept = req_valid_i && req_ready_o;
  assign b_fire = b_valid_i && b_ready_o;

  // Head of the issue phase feeds the datapath
  assign iss_valid_o = (issue_cnt_q != '0);
  assign iss_addr_o  = addr_q[issue_pnt_q];
  assign iss_bytes_o = bytes_q[issue_pnt_q];
  assign iss_eew_o   = eew_q[issue_pnt_q];
  assign iss_vm_o    = vm_q[issue_pnt_q];

  always_comb begin
    out_cnt_d = out_cnt_q;
    issued_d  = issued_q;
    // AW requests always belong to the issuing instruction
    if (aw_fire_i) begin
      out_cnt_d[issue_pnt_q] = out_cnt_d[issue_pnt_q] + 1'b1;
    end
    if (ag_insn_last_i) begin
      issued_d[issue_pnt_q] = 1'b1;
    end
    // Responses come back in order, oldest instruction first
    if (b_fire) begin
      out_cnt_d[commit_pnt_q] = out_cnt_d[commit_pnt_q] - 1'b1;
    end
    // Fresh entry starts with nothing outstanding
    if (accept) begin
      out_cnt_d[accept_pnt_q] = '0;
      issued_d[accept_pnt_q]  = 1'b0;
    end
  end

  // Last response of a fully issued instruction
  assign retire = b_fire && (commit_cnt_q != '0) && issued_q[commit_pnt_q] &&
                  (out_cnt_d[commit_pnt_q] == '0);

  always_comb begin
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    if (accept && !pk_insn_done_i) begin
      issue_cnt_d = issue_cnt_q + 1'b1;
    end else if (!accept && pk_insn_done_i) begin
      issue_cnt_d = issue_cnt_q - 1'b1;
    end
    if (accept && !retire) begin
      commit_cnt_d = commit_cnt_q + 1'b1;
    end else if (!accept && retire) begin
      commit_cnt_d = commit_cnt_q - 1'b1;
    end
  end

  // Store the request, vl scaled to bytes by the element width
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]    <= req_id_i;
      addr_q[accept_pnt_q]  <= req_addr_i;
      bytes_q[accept_pnt_q] <= vst_pkg::nbytes_t'(req_vl_i) << req_eew_i;
      eew_q[accept_pnt_q]   <= req_eew_i;
      vm_q[accept_pnt_q]    <= req_vm_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      out_cnt_q    <= '0;
      issued_q     <= '0;
      req_ready_q  <= 1'b0;
      b_ready_q    <= 1'b0;
      done_valid_q <= 1'b0;
      done_id_q    <= '0;
    end else begin
      // Pointers wrap with the power of two depth
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (pk_insn_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (retire) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
        done_id_q    <= id_q[commit_pnt_q];
      end
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      out_cnt_q    <= out_cnt_d;
      issued_q     <= issued_d;
      // Ready tracks queue not full for the coming cycle
      req_ready_q  <= (commit_cnt_d != vst_pkg::qcnt_t'(vst_pkg::QueueDepth));
      b_ready_q    <= 1'b1;
      done_valid_q <= retire;
    end
  end

  assign req_ready_o     = req_ready_q;
  assign b_ready_o       = b_ready_q;
  assign store_pending_o = (commit_cnt_q != '0);
  assign done_valid_o    = done_valid_q;
  assign done_id_o       = done_id_q;

endmodule

// ==== design/vst_pkg.sv ====
package vst_pkg;

  // Lane count and bus geometry are fixed for this unit
  localparam int unsigned NrLanes       = 2;
  localparam int unsigned BeatBytes     = 8;
  // One lane operand word holds 8 bytes per lane
  localparam int unsigned LaneWordBytes = NrLanes * 8;

  // In-flight instruction storage
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned NrInsnIds     = 4;

  // Burst shape on the memory port
  localparam int unsigned MaxBurstBeats = 4;
  localparam int unsigned BurstBytes    = MaxBurstBeats * BeatBytes;

  // Longest vector in elements
  localparam int unsigned MaxVl         = 256;

  // Byte address on the memory port
  typedef logic [31:0] addr_t;

  // One lane operand word, also one write beat
  typedef logic [8*BeatBytes-1:0] elen_t;

  // Byte strobes of one 64-bit word
  typedef logic [BeatBytes-1:0] strb_t;

  // Vector length, must reach MaxVl itself
  typedef logic [$clog2(MaxVl):0] vlen_t;

  // Byte count of one instruction, up to 256 x 8 bytes
  typedef logic [11:0] nbytes_t;

  typedef logic [$clog2(NrInsnIds)-1:0] insn_id_t;

  // AW length field, beats minus one
  typedef logic [$clog2(MaxBurstBeats)-1:0] burst_len_t;

  // Queue pointers and occupancy
  typedef logic [$clog2(QueueDepth)-1:0] qptr_t;
  typedef logic [$clog2(QueueDepth):0]   qcnt_t;

  // Outstanding B responses of one instruction, 64 bursts at most
  typedef logic [6:0] burst_cnt_t;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Address generator FSM
  typedef enum logic {
    AG_IDLE,
    AG_REQ
  } addrgen_state_e;

endpackage

// ==== design/vst_top.sv ====
`timescale 1ns/1ns

module vst_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer
  input  logic                                   req_valid_i,
  input  vst_pkg::insn_id_t                      req_id_i,
  input  vst_pkg::addr_t                         req_addr_i,
  input  vst_pkg::vlen_t                         req_vl_i,
  input  vst_pkg::eew_e                          req_eew_i,
  input  logic                                   req_vm_i,
  output logic                                   req_ready_o,
  // Lanes
  input  vst_pkg::elen_t [vst_pkg::NrLanes-1:0]  opnd_i,
  input  logic                                   opnd_valid_i,
  input  vst_pkg::strb_t [vst_pkg::NrLanes-1:0]  mask_i,
  output logic                                   opnd_ready_o,
  // AW channel
  output vst_pkg::addr_t                         aw_addr_o,
  output vst_pkg::burst_len_t                    aw_len_o,
  output logic                                   aw_valid_o,
  input  logic                                   aw_ready_i,
  // W channel
  output vst_pkg::elen_t                         w_data_o,
  output vst_pkg::strb_t                         w_strb_o,
  output logic                                   w_last_o,
  output logic                                   w_valid_o,
  input  logic                                   w_ready_i,
  // B channel
  input  logic                                   b_valid_i,
  output logic                                   b_ready_o,
  // Status
  output logic                                   store_pending_o,
  output logic                                   done_valid_o,
  output vst_pkg::insn_id_t                      done_id_o
);

  // Issuing instruction
  logic                iss_valid;
  vst_pkg::addr_t      iss_addr;
  vst_pkg::nbytes_t    iss_bytes;
  vst_pkg::eew_e       iss_eew;
  logic                iss_vm;

  // Burst handoff and events
  logic                aw_fire;
  logic                ag_insn_last;
  logic                burst_valid;
  vst_pkg::burst_len_t burst_len;
  logic                burst_done;
  logic                pk_insn_done;

  vst_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_id_i        (req_id_i),
    .req_addr_i      (req_addr_i),
    .req_vl_i        (req_vl_i),
    .req_eew_i       (req_eew_i),
    .req_vm_i        (req_vm_i),
    .req_ready_o     (req_ready_o),
    .iss_valid_o     (iss_valid),
    .iss_addr_o      (iss_addr),
    .iss_bytes_o     (iss_bytes),
    .iss_eew_o       (iss_eew),
    .iss_vm_o        (iss_vm),
    .aw_fire_i       (aw_fire),
    .ag_insn_last_i  (ag_insn_last),
    .pk_insn_done_i  (pk_insn_done),
    .b_valid_i       (b_valid_i),
    .b_ready_o       (b_ready_o),
    .store_pending_o (store_pending_o),
    .done_valid_o    (done_valid_o),
    .done_id_o       (done_id_o)
  );

  vst_addrgen i_addrgen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .iss_valid_i    (iss_valid),
    .iss_addr_i     (iss_addr),
    .iss_bytes_i    (iss_bytes),
    .aw_addr_o      (aw_addr_o),
    .aw_len_o       (aw_len_o),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready_i),
    .aw_fire_o      (aw_fire),
    .ag_insn_last_o (ag_insn_last),
    .burst_valid_o  (burst_valid),
    .burst_len_o    (burst_len),
    .burst_done_i   (burst_done)
  );

  vst_beat_packer i_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .iss_valid_i    (iss_valid),
    .iss_bytes_i    (iss_bytes),
    .iss_eew_i      (iss_eew),
    .iss_vm_i       (iss_vm),
    .burst_valid_i  (burst_valid),
    .burst_len_i    (burst_len),
    .burst_done_o   (burst_done),
    .pk_insn_done_o (pk_insn_done),
    .opnd_i         (opnd_i),
    .opnd_valid_i   (opnd_valid_i),
    .mask_i         (mask_i),
    .opnd_ready_o   (opnd_ready_o),
    .w_data_o       (w_data_o),
    .w_strb_o       (w_strb_o),
    .w_last_o       (w_last_o),
    .w_valid_o      (w_valid_o),
    .w_ready_i      (w_ready_i)
  );

endmodule

// ==== dv/vst_checker.sv ====
`timescale 1ns/1ns

module vst_checker (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                w_valid_o,
  input logic                w_ready_i,
  input vst_pkg::elen_t      w_data_o,
  input logic                aw_valid_o,
  input logic                aw_ready_i,
  input vst_pkg::addr_t      aw_addr_o,
  input logic                done_valid_o,
  input vst_pkg::insn_id_t   done_id_o
);

  // Stalled write beat keeps its payload
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else $error("W beat dropped or changed while stalled");

  // Stalled address request keeps its address
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
    else $error("AW request dropped or changed while stalled");

  a_done_rst: assert property (@(posedge clk_i) !rst_ni |-> !done_valid_o)
    else $error("done_valid_o high during reset");

  // Completion is a single pulse per instruction
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |=> !(done_valid_o && $stable(done_id_o)))
    else $error("done_valid_o repeated with the same ID");

endmodule

// ==== dv/vst_tb.sv ====
`timescale 1ns/1ns

module vst_tb;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i;
  vst_pkg::insn_id_t req_id_i;
  vst_pkg::addr_t req_addr_i;
  vst_pkg::vlen_t req_vl_i;
  vst_pkg::eew_e req_eew_i;
  logic req_vm_i;
  logic req_ready_o;
  vst_pkg::elen_t [vst_pkg::NrLanes-1:0] opnd_i;
  vst_pkg::strb_t [vst_pkg::NrLanes-1:0] mask_i;
  logic opnd_valid_i, opnd_ready_o;
  vst_pkg::addr_t aw_addr_o;
  vst_pkg::burst_len_t aw_len_o;
  logic aw_valid_o, aw_ready_i;
  vst_pkg::elen_t w_data_o;
  vst_pkg::strb_t w_strb_o;
  logic w_last_o, w_valid_o, w_ready_i;
  logic b_valid_i, b_ready_o;
  logic store_pending_o, done_valid_o;
  vst_pkg::insn_id_t done_id_o;

  // Raw test vectors, entry 0 is the record count
  logic [143:0] tv [0:63];
  logic [67:0]  req_q[$];
  logic [143:0] lane_q[$];
  logic [63:0]  exp_data_q[$];
  logic [63:0]  exp_keep_q[$];
  logic [7:0]   exp_strb_q[$];
  logic         exp_last_q[$];
  logic [31:0]  exp_addr_q[$];
  logic [1:0]   exp_len_q[$];
  logic [1:0]   exp_id_q[$];

  int n_rec, n_acc, n_done, pend_b, cycles, limit;
  logic opnd_fire, b_fire, saw_full;

  vst_top DUT (.*);

  bind vst_top vst_checker i_checker (.*);

  always #2 clk_i = ~clk_i;

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  // Expected AW and beats follow from base, byte count and the lane words
  task automatic load_tests();
    logic [143:0] w;
    logic [143:0] lw;
    logic [63:0] d, keep;
    logic [7:0] s;
    int ptr, wbase, bytes, eew, vm, beats, bursts, idx, off, est, rem;
    $readmemh("dv/vst_tests.txt", tv);
    n_rec = int'(tv[0]);
    ptr = 1;
    for (int r = 0; r < n_rec; r++) begin
      w = tv[ptr];
      ptr++;
      req_q.push_back(w[67:0]);
      eew = int'(w[23:20]);
      vm = int'(w[19:16]);
      bytes = int'(w[35:24]) << eew;
      bursts = int'(w[11:8]);
      beats = int'(w[7:0]);
      exp_id_q.push_back(w[13:12]);
      wbase = ptr;
      for (int k = 0; k < (bytes + 15) / 16; k++) begin
        lane_q.push_back(tv[ptr]);
        ptr++;
      end
      for (int b = 0; b < bursts; b++) begin
        rem = bytes - 32 * b;
        exp_addr_q.push_back(w[67:36] + 32'(32 * b));
        exp_len_q.push_back(2'(((rem > 32 ? 32 : rem) + 7) / 8 - 1));
      end
      for (int j = 0; j < beats; j++) begin
        d = '0;
        s = '0;
        keep = '0;
        for (int b = 0; b < 8; b++) begin
          idx = 8 * j + b;
          if (idx < bytes) begin
            lw = tv[wbase + idx / 16];
            off = idx % 16;
            // Mask bit of the element's first byte
            est = off - off % (1 << eew);
            d[8*b +: 8] = lw[8*off +: 8];
            s[b] = (vm != 0) || lw[128 + est];
            keep[8*b +: 8] = 8'hff;
          end
        end
        exp_data_q.push_back(d);
        exp_strb_q.push_back(s);
        exp_keep_q.push_back(keep);
        exp_last_q.push_back((j % 4 == 3) || (j == beats - 1));
      end
    end
  endtask

  initial begin
    void'($urandom(25562));
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_id_i = '0;
    req_addr_i = '0;
    req_vl_i = '0;
    req_eew_i = vst_pkg::EW8;
    req_vm_i = 1'b0;
    opnd_i = '0;
    mask_i = '0;
    opnd_valid_i = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    {n_acc, n_done, pend_b, cycles} = '0;
    {opnd_fire, b_fire, saw_full} = '0;
    load_tests();
    limit = 200 * n_rec + 100;
    repeat (5) @(posedge clk_i);
    check("outputs low in reset", 64'({req_ready_o, aw_valid_o, w_valid_o, opnd_ready_o,
          done_valid_o, store_pending_o}), 64'(0));
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Requests go back to back, a stall here means the queue is full
    while (req_q.size() > 0) begin
      req_addr_i = req_q[0][67:36];
      req_vl_i = vst_pkg::vlen_t'(req_q[0][35:24]);
      req_eew_i = vst_pkg::eew_e'(req_q[0][21:20]);
      req_vm_i = req_q[0][16];
      req_id_i = req_q[0][13:12];
      req_valid_i = 1'b1;
      @(posedge clk_i);
      while (!req_ready_o) begin
        saw_full = 1'b1;
        @(posedge clk_i);
      end
      void'(req_q.pop_front());
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
    while (n_done < n_rec) @(posedge clk_i);
    @(negedge clk_i);
    check("beats left", 64'(exp_data_q.size()), 64'(0));
    check("bursts left", 64'(exp_addr_q.size()), 64'(0));
    check("lane words left", 64'(lane_q.size()), 64'(0));
    check("store_pending_o at end", 64'(store_pending_o), 64'(0));
    check("queue full seen", 64'(saw_full), 64'(1));
    $display("Test passed");
    $finish;
  end

  // Random ready and valid stalls, payloads held until taken
  // Stalls start after the first clock edge out of reset
  always @(negedge clk_i) begin
    if (cycles > 0) begin
      aw_ready_i = ($urandom % 4) != 0;
      w_ready_i = ($urandom % 3) != 0;
      if (opnd_fire) begin
        void'(lane_q.pop_front());
        opnd_valid_i = 1'b0;
      end
      if (!opnd_valid_i && lane_q.size() > 0 && ($urandom % 4) != 0) begin
        opnd_i[0] = lane_q[0][63:0];
        opnd_i[1] = lane_q[0][127:64];
        mask_i[0] = lane_q[0][135:128];
        mask_i[1] = lane_q[0][143:136];
        opnd_valid_i = 1'b1;
      end
      if (b_fire) b_valid_i = 1'b0;
      if (!b_valid_i && pend_b > 0 && ($urandom % 2) != 0) b_valid_i = 1'b1;
    end
  end

  // Memory side monitor, sees the values settled before each edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      if (cycles >= limit) begin
        $display("Timeout: run exceeded %0d cycles without finishing", limit);
        $display("Test failed");
        $fatal(1, "timeout");
      end
      if (aw_valid_o && aw_ready_i) begin
        if (exp_addr_q.size() == 0) stop_run("Unexpected AW burst");
        check("AW address", 64'(aw_addr_o), 64'(exp_addr_q.pop_front()));
        check("AW length", 64'(aw_len_o), 64'(exp_len_q.pop_front()));
      end
      if (w_valid_o && w_ready_i) begin
        if (exp_data_q.size() == 0) stop_run("Unexpected W beat");
        check("W data", w_data_o & exp_keep_q.pop_front(), exp_data_q.pop_front());
        check("W strobe", 64'(w_strb_o), 64'(exp_strb_q.pop_front()));
        check("W last", 64'(w_last_o), 64'(exp_last_q.pop_front()));
        if (w_last_o) pend_b++;
      end
      b_fire = b_valid_i && b_ready_o;
      if (b_fire) pend_b--;
      opnd_fire = opnd_valid_i && opnd_ready_o;
      if (done_valid_o) begin
        if (exp_id_q.size() == 0) stop_run("Unexpected completion");
        check("done ID", 64'(done_id_o), 64'(exp_id_q.pop_front()));
        n_done++;
      end
      // Nothing pending only once every accepted store is done
      if (!store_pending_o) check("dones when idle", 64'(n_done), 64'(n_acc));
      if (req_valid_i && req_ready_o) n_acc++;
    end
  end

endmodule

// ==== dv/vst_tests.txt ====
// Record count, then per record one instruction line and its lane words
// Insn: addr(8) vl(3) eew(1) vm(1) id(1) bursts(1) beats(2); lane: mask1 mask0 opnd1 opnd0
8
// EW64 vl 3 unmasked
00001000003310103
00000f0e0d0c0b0a09080706050403020100
00001f1e1d1c1b1a19181716151413121110
// EW8 vl 40, two bursts
00002000028011205
00002f2e2d2c2b2a29282726252423222120
00003f3e3d3c3b3a39383736353433323130
00004f4e4d4c4b4a49484746454443424140
// EW16 vl 8 masked
00003000008102102
44055f5e5d5c5b5a59585756555453525150
// Four back to back EW32 stores
00004000004213102
00006f6e6d6c6b6a69686766656463626160
00004100004210102
00007f7e7d7c7b7a79787776757473727170
00004200004211102
00008f8e8d8c8b8a89888786858483828180
00004300004212102
00009f9e9d9c9b9a99989796959493929190
// EW8 vl 5 masked, partial beat
00005000005000101
001aafaeadacabaaa9a8a7a6a5a4a3a2a1a0

// ==== vst.f ====
design/vst_pkg.sv
design/vst_ctrl.sv
design/vst_addrgen.sv
design/vst_beat_packer.sv
design/vst_top.sv
dv/vst_checker.sv
dv/vst_tb.sv
